//--- dm_pkg.sv
// ---------------------------------------
// debug module register file definitions
// sizes, register map, field positions
// ---------------------------------------
package dm_pkg;

  // sizes
  localparam int unsigned NrHarts     = 2;
  localparam int unsigned DataCount   = 2;
  localparam int unsigned ProgBufSize = 4;

  typedef logic [6:0]         dmi_addr_t;
  typedef logic [31:0]        dmi_data_t;
  typedef logic [NrHarts-1:0] hart_vec_t;
  typedef logic [9:0]         hart_sel_t;

  typedef dmi_data_t [DataCount-1:0]   data_vec_t;
  typedef dmi_data_t [ProgBufSize-1:0] progbuf_vec_t;

  typedef enum logic [1:0] {
    DtmNop   = 2'd0,
    DtmRead  = 2'd1,
    DtmWrite = 2'd2
  } dtm_op_e;

  typedef enum logic [2:0] {
    CmdErrNone         = 3'd0,
    CmdErrBusy         = 3'd1,
    CmdErrNotSupported = 3'd2,
    CmdErrException    = 3'd3,
    CmdErrHaltResume   = 3'd4,
    CmdErrBus          = 3'd5,
    CmdErrOther        = 3'd7
  } cmderr_e;

  // register map
  localparam dmi_addr_t AddrData0      = 7'h04;
  localparam dmi_addr_t AddrDmControl  = 7'h10;
  localparam dmi_addr_t AddrDmStatus   = 7'h11;
  localparam dmi_addr_t AddrAbstractCs = 7'h16;
  localparam dmi_addr_t AddrCommand    = 7'h17;
  localparam dmi_addr_t AddrProgBuf0   = 7'h20;

  // spec version 0.13
  localparam logic [3:0] DbgVersion = 4'd2;

  // ---------------------------------------
  // field positions, lowest bit of a field
  // ---------------------------------------
  // dmcontrol
  localparam int unsigned CtrlDmActive     = 0;
  localparam int unsigned CtrlNdmReset     = 1;
  localparam int unsigned CtrlHartSel      = 16;
  localparam int unsigned CtrlAckHaveReset = 28;
  localparam int unsigned CtrlResumeReq    = 30;
  localparam int unsigned CtrlHaltReq      = 31;

  // dmstatus, each all flag sits one above its any flag
  localparam int unsigned StVersion       = 0;
  localparam int unsigned StAuthenticated = 7;
  localparam int unsigned StAnyHalted     = 8;
  localparam int unsigned StAnyRunning    = 10;
  localparam int unsigned StAnyUnavail    = 12;
  localparam int unsigned StAnyNonExist   = 14;
  localparam int unsigned StAnyResumeAck  = 16;
  localparam int unsigned StAnyHaveReset  = 18;

  // abstractcs
  localparam int unsigned AcsDataCount   = 0;
  localparam int unsigned AcsCmdErr      = 8;
  localparam int unsigned AcsBusy        = 12;
  localparam int unsigned AcsProgBufSize = 24;

endpackage

//--- dm_reg_if.sv
// ---------------------------------------
// internal register access bus
// ---------------------------------------
`timescale 1ns/100ps

interface dm_reg_if;
  import dm_pkg::*;

  // one-cycle strobe per accepted request
  logic      req;
  logic      we;
  dmi_addr_t addr;
  dmi_data_t wdata;
  // zero unless addr hits this block
  dmi_data_t rdata;

  modport bus (
    output req, we, addr, wdata,
    input  rdata
  );

  modport regs (
    input  req, we, addr, wdata,
    output rdata
  );

endinterface

//--- dm_resp_fifo.sv
// ---------------------------------------
// two-entry response queue
// ---------------------------------------
`timescale 1ns/100ps

module dm_resp_fifo (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              push_i,
  input  dm_pkg::dmi_data_t wdata_i,
  output logic              full_o,
  input  logic              pop_i,
  output dm_pkg::dmi_data_t rdata_o,
  output logic              valid_o
);
  import dm_pkg::*;

  dmi_data_t  mem_q [2];
  logic       wptr_q, rptr_q;
  logic [1:0] count_q;
  logic       do_push, do_pop;

  assign full_o  = (count_q == 2'd2);
  assign valid_o = (count_q != 2'd0);
  assign rdata_o = mem_q[rptr_q];

  // a pop frees its slot first, so a full queue still takes a push
  assign do_pop  = pop_i & valid_o;
  assign do_push = push_i & (~full_o | do_pop);

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wptr_q] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= 1'b0;
      rptr_q  <= 1'b0;
      count_q <= 2'd0;
    end else begin
      if (do_push) wptr_q <= ~wptr_q;
      if (do_pop)  rptr_q <= ~rptr_q;
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

//--- dm_hart_ctrl.sv
// ---------------------------------------
// hart control and status registers
// halt/resume requests per selected hart
// ---------------------------------------
`timescale 1ns/100ps

module dm_hart_ctrl (
  input  logic              clk_i,
  input  logic              rst_ni,
  dm_reg_if.regs            bus,
  input  dm_pkg::hart_vec_t halted_i,
  input  dm_pkg::hart_vec_t unavailable_i,
  input  dm_pkg::hart_vec_t resumeack_i,
  output logic              dmactive_o,
  output logic              ndmreset_o,
  output dm_pkg::hart_vec_t haltreq_o,
  output dm_pkg::hart_vec_t resumereq_o,
  output logic              clear_resumeack_o
);
  import dm_pkg::*;

  logic      dmactive_d, dmactive_q;
  logic      ndmreset_d, ndmreset_q;
  logic      haltreq_d, haltreq_q;
  logic      resumereq_d, resumereq_q;
  hart_sel_t hartsel_d, hartsel_q;
  hart_vec_t havereset_d, havereset_q;
  hart_vec_t sel_onehot;
  logic      sel_exists, sel_halted, sel_unavail, sel_resumeack, sel_havereset;
  logic      ctrl_write;
  dmi_data_t dmcontrol, dmstatus;

  // hart select decode, all zero when out of range
  always_comb begin
    sel_onehot = '0;
    for (int h = 0; h < NrHarts; h++) begin
      sel_onehot[h] = (hartsel_q == hart_sel_t'(h));
    end
  end

  assign sel_exists    = |sel_onehot;
  assign sel_halted    = |(halted_i & sel_onehot);
  assign sel_unavail   = |(unavailable_i & sel_onehot);
  assign sel_resumeack = |(resumeack_i & sel_onehot);
  assign sel_havereset = |(havereset_q & sel_onehot);

  // ---------------------------------------
  // read side
  // ---------------------------------------
  always_comb begin
    dmcontrol = '0;
    dmcontrol[CtrlDmActive]        = dmactive_q;
    dmcontrol[CtrlNdmReset]        = ndmreset_q;
    dmcontrol[CtrlHartSel +: 10]   = hartsel_q;
    dmcontrol[CtrlResumeReq]       = resumereq_q;
    dmcontrol[CtrlHaltReq]         = haltreq_q;

    // any and all agree with a single selected hart
    dmstatus = '0;
    dmstatus[StVersion +: 4]       = DbgVersion;
    dmstatus[StAuthenticated]      = 1'b1;
    dmstatus[StAnyHalted +: 2]     = {2{sel_halted & ~sel_unavail}};
    dmstatus[StAnyRunning +: 2]    = {2{sel_exists & ~sel_halted & ~sel_unavail}};
    dmstatus[StAnyUnavail +: 2]    = {2{sel_unavail}};
    dmstatus[StAnyNonExist +: 2]   = {2{~sel_exists}};
    dmstatus[StAnyResumeAck +: 2]  = {2{sel_resumeack}};
    dmstatus[StAnyHaveReset +: 2]  = {2{sel_havereset}};

    case (bus.addr)
      AddrDmControl: bus.rdata = dmcontrol;
      AddrDmStatus:  bus.rdata = dmstatus;
      default:       bus.rdata = '0;
    endcase
  end

  // ---------------------------------------
  // write side
  // ---------------------------------------
  assign ctrl_write = bus.req & bus.we & (bus.addr == AddrDmControl);

  // resumeack is cleared as resumereq rises
  assign clear_resumeack_o = ctrl_write & ~resumereq_q & bus.wdata[CtrlResumeReq];

  always_comb begin
    dmactive_d  = dmactive_q;
    ndmreset_d  = ndmreset_q;
    haltreq_d   = haltreq_q;
    resumereq_d = resumereq_q;
    hartsel_d   = hartsel_q;
    havereset_d = havereset_q;
    if (ctrl_write) begin
      dmactive_d  = bus.wdata[CtrlDmActive];
      ndmreset_d  = bus.wdata[CtrlNdmReset];
      haltreq_d   = bus.wdata[CtrlHaltReq];
      resumereq_d = bus.wdata[CtrlResumeReq];
      hartsel_d   = bus.wdata[CtrlHartSel +: 10];
      if (bus.wdata[CtrlAckHaveReset]) begin
        havereset_d = havereset_q & ~sel_onehot;
      end
    end
    // hart acknowledged the resume
    if (resumereq_q && sel_resumeack) begin
      resumereq_d = 1'b0;
    end
    if (ndmreset_q) begin
      havereset_d = '1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dmactive_q  <= 1'b0;
      ndmreset_q  <= 1'b0;
      haltreq_q   <= 1'b0;
      resumereq_q <= 1'b0;
      hartsel_q   <= '0;
      havereset_q <= '1;
    end else begin
      havereset_q <= havereset_d;
      dmactive_q  <= dmactive_d;
      // inactive module holds everything else cleared
      if (!dmactive_q) begin
        ndmreset_q  <= 1'b0;
        haltreq_q   <= 1'b0;
        resumereq_q <= 1'b0;
        hartsel_q   <= '0;
      end else begin
        ndmreset_q  <= ndmreset_d;
        haltreq_q   <= haltreq_d;
        resumereq_q <= resumereq_d;
        hartsel_q   <= hartsel_d;
      end
    end
  end

  assign dmactive_o  = dmactive_q;
  assign ndmreset_o  = ndmreset_q;
  assign haltreq_o   = {NrHarts{haltreq_q}} & sel_onehot;
  assign resumereq_o = {NrHarts{resumereq_q}} & sel_onehot;

endmodule

//--- dm_abstract_cmd.sv
// ---------------------------------------
// abstract command, data and progbuf regs
// ---------------------------------------
`timescale 1ns/100ps

module dm_abstract_cmd (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  dm_reg_if.regs               bus,
  input  logic                 dmactive_i,
  input  logic                 cmdbusy_i,
  input  logic                 cmderror_valid_i,
  input  dm_pkg::cmderr_e      cmderror_i,
  input  logic                 data_valid_i,
  input  dm_pkg::data_vec_t    data_i,
  output logic                 cmd_valid_o,
  output dm_pkg::dmi_data_t    cmd_o,
  output dm_pkg::data_vec_t    data_o,
  output dm_pkg::progbuf_vec_t progbuf_o
);
  import dm_pkg::*;

  dmi_data_t    command_d, command_q;
  logic         cmd_valid_d, cmd_valid_q;
  cmderr_e      cmderr_d, cmderr_q;
  data_vec_t    data_d, data_q;
  progbuf_vec_t progbuf_d, progbuf_q;
  dmi_data_t    abstractcs;
  logic         wr_en, busy_err;

  assign wr_en = bus.req & bus.we;

  always_comb begin
    abstractcs = '0;
    abstractcs[AcsDataCount +: 4]   = 4'(DataCount);
    abstractcs[AcsCmdErr +: 3]      = cmderr_q;
    abstractcs[AcsBusy]             = cmdbusy_i;
    abstractcs[AcsProgBufSize +: 5] = 5'(ProgBufSize);
  end

  // read mux, command reads as zero
  always_comb begin
    bus.rdata = '0;
    if (bus.addr == AddrAbstractCs) bus.rdata = abstractcs;
    for (int i = 0; i < DataCount; i++) begin
      if (bus.addr == dmi_addr_t'(AddrData0 + i)) bus.rdata = data_q[i];
    end
    for (int i = 0; i < ProgBufSize; i++) begin
      if (bus.addr == dmi_addr_t'(AddrProgBuf0 + i)) bus.rdata = progbuf_q[i];
    end
  end

  // ---------------------------------------
  // next state
  // ---------------------------------------
  always_comb begin
    command_d   = command_q;
    cmd_valid_d = 1'b0;
    cmderr_d    = cmderr_q;
    data_d      = data_q;
    progbuf_d   = progbuf_q;
    busy_err    = 1'b0;
    if (wr_en) begin
      for (int i = 0; i < DataCount; i++) begin
        if (bus.addr == dmi_addr_t'(AddrData0 + i)) begin
          if (cmdbusy_i) busy_err = 1'b1;
          else           data_d[i] = bus.wdata;
        end
      end
      for (int i = 0; i < ProgBufSize; i++) begin
        if (bus.addr == dmi_addr_t'(AddrProgBuf0 + i)) begin
          if (cmdbusy_i) busy_err = 1'b1;
          else           progbuf_d[i] = bus.wdata;
        end
      end
      if (bus.addr == AddrCommand) begin
        if (cmdbusy_i) begin
          busy_err = 1'b1;
        end else begin
          cmd_valid_d = 1'b1;
          command_d   = bus.wdata;
        end
      end
      // cmderr is write-one-to-clear
      if (bus.addr == AddrAbstractCs) begin
        if (cmdbusy_i) busy_err = 1'b1;
        else           cmderr_d = cmderr_e'(cmderr_q & ~bus.wdata[AcsCmdErr +: 3]);
      end
    end
    // first error sticks
    if (busy_err && cmderr_q == CmdErrNone) begin
      cmderr_d = CmdErrBusy;
    end
    // error from the hart wins over a bus write
    if (cmderror_valid_i) cmderr_d = cmderror_i;
    if (data_valid_i)     data_d   = data_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      command_q   <= '0;
      cmd_valid_q <= 1'b0;
      cmderr_q    <= CmdErrNone;
      data_q      <= '0;
      progbuf_q   <= '0;
    end else if (!dmactive_i) begin
      command_q   <= '0;
      cmd_valid_q <= 1'b0;
      cmderr_q    <= CmdErrNone;
      data_q      <= '0;
      progbuf_q   <= '0;
    end else begin
      command_q   <= command_d;
      cmd_valid_q <= cmd_valid_d;
      cmderr_q    <= cmderr_d;
      data_q      <= data_d;
      progbuf_q   <= progbuf_d;
    end
  end

  assign cmd_valid_o = cmd_valid_q;
  assign cmd_o       = command_q;
  assign data_o      = data_q;
  assign progbuf_o   = progbuf_q;

endmodule

//--- dm_csrs.sv
// ---------------------------------------
// debug module registers, DMI front end
// ---------------------------------------
`timescale 1ns/100ps

module dm_csrs (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 dmi_req_valid_i,
  output logic                 dmi_req_ready_o,
  input  dm_pkg::dmi_addr_t    dmi_req_addr_i,
  input  dm_pkg::dtm_op_e      dmi_req_op_i,
  input  dm_pkg::dmi_data_t    dmi_req_data_i,
  output logic                 dmi_resp_valid_o,
  input  logic                 dmi_resp_ready_i,
  output dm_pkg::dmi_data_t    dmi_resp_data_o,
  output logic                 ndmreset_o,
  output logic                 dmactive_o,
  input  dm_pkg::hart_vec_t    halted_i,
  input  dm_pkg::hart_vec_t    unavailable_i,
  input  dm_pkg::hart_vec_t    resumeack_i,
  output dm_pkg::hart_vec_t    haltreq_o,
  output dm_pkg::hart_vec_t    resumereq_o,
  output logic                 clear_resumeack_o,
  output logic                 cmd_valid_o,
  output dm_pkg::dmi_data_t    cmd_o,
  input  logic                 cmderror_valid_i,
  input  dm_pkg::cmderr_e      cmderror_i,
  input  logic                 cmdbusy_i,
  output dm_pkg::progbuf_vec_t progbuf_o,
  output dm_pkg::data_vec_t    data_o,
  input  dm_pkg::data_vec_t    data_i,
  input  logic                 data_valid_i
);
  import dm_pkg::*;

  logic      req_accept, resp_pop, resp_full;
  dmi_data_t rdata_all, resp_word;

  dm_reg_if hart_bus ();
  dm_reg_if cmd_bus ();

  // handshake
  assign dmi_req_ready_o = ~resp_full;
  assign req_accept      = dmi_req_valid_i & dmi_req_ready_o;
  assign resp_pop        = dmi_resp_valid_o & dmi_resp_ready_i;

  // same request goes to both register blocks
  assign hart_bus.req   = req_accept;
  assign hart_bus.we    = (dmi_req_op_i == DtmWrite);
  assign hart_bus.addr  = dmi_req_addr_i;
  assign hart_bus.wdata = dmi_req_data_i;
  assign cmd_bus.req    = req_accept;
  assign cmd_bus.we     = (dmi_req_op_i == DtmWrite);
  assign cmd_bus.addr   = dmi_req_addr_i;
  assign cmd_bus.wdata  = dmi_req_data_i;

  // writes and nops answer with zero
  assign rdata_all = hart_bus.rdata | cmd_bus.rdata;
  assign resp_word = (dmi_req_op_i == DtmRead) ? rdata_all : '0;

  dm_hart_ctrl i_hart_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .bus               (hart_bus.regs),
    .halted_i          (halted_i),
    .unavailable_i     (unavailable_i),
    .resumeack_i       (resumeack_i),
    .dmactive_o        (dmactive_o),
    .ndmreset_o        (ndmreset_o),
    .haltreq_o         (haltreq_o),
    .resumereq_o       (resumereq_o),
    .clear_resumeack_o (clear_resumeack_o)
  );

  dm_abstract_cmd i_abstract_cmd (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .bus              (cmd_bus.regs),
    .dmactive_i       (dmactive_o),
    .cmdbusy_i        (cmdbusy_i),
    .cmderror_valid_i (cmderror_valid_i),
    .cmderror_i       (cmderror_i),
    .data_valid_i     (data_valid_i),
    .data_i           (data_i),
    .cmd_valid_o      (cmd_valid_o),
    .cmd_o            (cmd_o),
    .data_o           (data_o),
    .progbuf_o        (progbuf_o)
  );

  dm_resp_fifo i_resp_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (req_accept),
    .wdata_i (resp_word),
    .full_o  (resp_full),
    .pop_i   (resp_pop),
    .rdata_o (dmi_resp_data_o),
    .valid_o (dmi_resp_valid_o)
  );

endmodule

//--- dm_csrs_checker.sv
// ---------------------------------------
// concurrent checks on the DMI top level
// ---------------------------------------
`timescale 1ns/100ps

module dm_csrs_checker (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              dmi_resp_valid_o,
  input logic              dmi_resp_ready_i,
  input dm_pkg::dmi_data_t dmi_resp_data_o,
  input logic              cmd_valid_o,
  input dm_pkg::hart_vec_t haltreq_o
);

  // failures seen by the assertions below
  int unsigned assert_fails = 0;

  // held response keeps valid and data
  resp_data_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    dmi_resp_valid_o && !dmi_resp_ready_i |=> dmi_resp_valid_o && $stable(dmi_resp_data_o)
  ) else begin
    assert_fails++;
    $error("response data changed while the response was held");
  end

  // command strobe is a single-cycle pulse
  cmd_valid_single: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    cmd_valid_o |=> !cmd_valid_o
  ) else begin
    assert_fails++;
    $error("cmd_valid_o stayed high for two cycles");
  end

  // at most one hart gets a halt request
  haltreq_onehot0: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $onehot0(haltreq_o)
  ) else begin
    assert_fails++;
    $error("haltreq_o has more than one bit set");
  end

endmodule

bind dm_csrs dm_csrs_checker checker_i (
  .clk_i            (clk_i),
  .rst_ni           (rst_ni),
  .dmi_resp_valid_o (dmi_resp_valid_o),
  .dmi_resp_ready_i (dmi_resp_ready_i),
  .dmi_resp_data_o  (dmi_resp_data_o),
  .cmd_valid_o      (cmd_valid_o),
  .haltreq_o        (haltreq_o)
);

//--- tb_dm_csrs.sv
// ---------------------------------------
// directed testbench for the DM registers
// ---------------------------------------
`timescale 1ns/100ps

module tb_dm_csrs;
  import dm_pkg::*;

  localparam int unsigned MaxWait = 50;

  logic         clk_i;
  logic         rst_ni;
  logic         dmi_req_valid_i;
  logic         dmi_req_ready_o;
  dmi_addr_t    dmi_req_addr_i;
  dtm_op_e      dmi_req_op_i;
  dmi_data_t    dmi_req_data_i;
  logic         dmi_resp_valid_o;
  logic         dmi_resp_ready_i;
  dmi_data_t    dmi_resp_data_o;
  logic         ndmreset_o;
  logic         dmactive_o;
  hart_vec_t    halted_i;
  hart_vec_t    unavailable_i;
  hart_vec_t    resumeack_i;
  hart_vec_t    haltreq_o;
  hart_vec_t    resumereq_o;
  logic         clear_resumeack_o;
  logic         cmd_valid_o;
  dmi_data_t    cmd_o;
  logic         cmderror_valid_i;
  cmderr_e      cmderror_i;
  logic         cmdbusy_i;
  progbuf_vec_t progbuf_o;
  data_vec_t    data_o;
  data_vec_t    data_i;
  logic         data_valid_i;

  int          errors;
  int          checks;
  int          tests;
  int          test_start_errors;
  int          resumeack_clears;
  int          cmd_pulses;
  logic [31:0] lcg_state;
  dmi_data_t   data_exp [DataCount];
  dmi_data_t   progbuf_exp [ProgBufSize];

  dm_csrs dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // count strobes in the middle of the cycle
  always @(negedge clk_i) begin
    if (clear_resumeack_o) resumeack_clears++;
    if (cmd_valid_o) cmd_pulses++;
  end

  function automatic dmi_data_t rand_word();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // expected dmstatus for the selected hart
  function automatic dmi_data_t status_word(input logic exists, input logic halted,
                                            input logic unavail, input logic resumeack,
                                            input logic havereset);
    dmi_data_t w;
    w = 32'h0000_0082;
    if (!exists) return w | 32'h0000_c000;
    if (halted && !unavail) w = w | 32'h0000_0300;
    if (!halted && !unavail) w = w | 32'h0000_0c00;
    if (unavail) w = w | 32'h0000_3000;
    if (resumeack) w = w | 32'h0003_0000;
    if (havereset) w = w | 32'h000c_0000;
    return w;
  endfunction

  // progbufsize 4, datacount 2
  function automatic dmi_data_t acs_word(input logic busy, input logic [2:0] err);
    return 32'h0400_0002 | (32'(busy) << 12) | (32'(err) << 8);
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAILED %s: expected %h, got %h", name, expected, actual);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("timeout while waiting for %s", what);
  endtask

  // starts and ends right after a rising edge
  task automatic dmi_issue(input dtm_op_e op, input dmi_addr_t addr, input dmi_data_t wdata);
    int   waited;
    logic accepted;
    waited   = 0;
    accepted = 1'b0;
    dmi_req_valid_i <= 1'b1;
    dmi_req_op_i    <= op;
    dmi_req_addr_i  <= addr;
    dmi_req_data_i  <= wdata;
    while (!accepted && waited < MaxWait) begin
      @(negedge clk_i);
      accepted = dmi_req_ready_o;
      @(posedge clk_i);
      waited++;
    end
    dmi_req_valid_i <= 1'b0;
    if (!accepted) report_timeout("dmi_req_ready_o");
  endtask

  task automatic dmi_collect(output dmi_data_t rdata);
    int   waited;
    logic seen;
    waited = 0;
    seen   = 1'b0;
    rdata  = '0;
    while (!seen && waited < MaxWait) begin
      @(negedge clk_i);
      if (dmi_resp_valid_o && dmi_resp_ready_i) begin
        seen  = 1'b1;
        rdata = dmi_resp_data_o;
      end
      @(posedge clk_i);
      waited++;
    end
    if (!seen) report_timeout("dmi_resp_valid_o");
  endtask

  task automatic dmi_write(input dmi_addr_t addr, input dmi_data_t wdata);
    dmi_data_t resp;
    dmi_issue(DtmWrite, addr, wdata);
    dmi_collect(resp);
    check_value("write response", '0, resp);
  endtask

  task automatic dmi_read(input dmi_addr_t addr, output dmi_data_t rdata);
    dmi_issue(DtmRead, addr, '0);
    dmi_collect(rdata);
  endtask

  task automatic read_check(input string name, input dmi_addr_t addr, input dmi_data_t expected);
    dmi_data_t rdata;
    dmi_read(addr, rdata);
    check_value(name, expected, rdata);
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (errors == test_start_errors) $display("%s: ok", name);
    else $display("%s: %0d errors", name, errors - test_start_errors);
    test_start_errors = errors;
  endtask

  task automatic test_reset_activation();
    check_value("dmi_req_ready_o", 1, dmi_req_ready_o);
    check_value("dmi_resp_valid_o", 0, dmi_resp_valid_o);
    check_value("cmd_valid_o", 0, cmd_valid_o);
    check_value("dmactive_o", 0, dmactive_o);
    check_value("ndmreset_o", 0, ndmreset_o);
    check_value("haltreq_o", 0, haltreq_o);
    check_value("resumereq_o", 0, resumereq_o);
    check_value("clear_resumeack_o", 0, clear_resumeack_o);
    read_check("dmcontrol", AddrDmControl, '0);
    dmi_write(AddrDmControl, 32'h0000_0001);
    read_check("dmcontrol", AddrDmControl, 32'h0000_0001);
    check_value("dmactive_o", 1, dmactive_o);
    read_check("dmstatus", AddrDmStatus, status_word(1, 0, 0, 0, 1));
  endtask

  task automatic test_halt_resume();
    int   clears;
    logic released;
    // select hart 1 with haltreq
    dmi_write(AddrDmControl, 32'h8001_0001);
    check_value("haltreq_o", 2'b10, haltreq_o);
    read_check("dmcontrol", AddrDmControl, 32'h8001_0001);
    halted_i <= 2'b10;
    read_check("dmstatus", AddrDmStatus, status_word(1, 1, 0, 0, 1));
    unavailable_i <= 2'b10;
    read_check("dmstatus", AddrDmStatus, status_word(1, 1, 1, 0, 1));
    halted_i      <= '0;
    unavailable_i <= '0;
    // ackhavereset for hart 1
    dmi_write(AddrDmControl, 32'h1001_0001);
    read_check("dmstatus", AddrDmStatus, status_word(1, 0, 0, 0, 0));
    clears = resumeack_clears;
    dmi_write(AddrDmControl, 32'h4001_0001);
    check_value("clear_resumeack_o pulses", clears + 1, resumeack_clears);
    check_value("resumereq_o", 2'b10, resumereq_o);
    check_value("haltreq_o", 0, haltreq_o);
    resumeack_i <= 2'b10;
    released = 1'b0;
    for (int w = 0; w < MaxWait && !released; w++) begin
      @(negedge clk_i);
      released = (resumereq_o == '0);
      @(posedge clk_i);
    end
    if (!released) report_timeout("resumereq_o to clear");
    read_check("dmstatus", AddrDmStatus, status_word(1, 0, 0, 1, 0));
    resumeack_i <= '0;
    // hart 5 does not exist
    dmi_write(AddrDmControl, 32'h8005_0001);
    check_value("haltreq_o", 0, haltreq_o);
    check_value("resumereq_o", 0, resumereq_o);
    read_check("dmstatus", AddrDmStatus, status_word(0, 0, 0, 0, 0));
  endtask

  task automatic test_data_progbuf();
    dmi_write(AddrDmControl, 32'h0000_0001);
    for (int i = 0; i < DataCount; i++) begin
      data_exp[i] = rand_word();
      dmi_write(dmi_addr_t'(AddrData0 + i), data_exp[i]);
    end
    for (int i = 0; i < ProgBufSize; i++) begin
      progbuf_exp[i] = rand_word();
      dmi_write(dmi_addr_t'(AddrProgBuf0 + i), progbuf_exp[i]);
    end
    for (int i = 0; i < DataCount; i++) begin
      read_check($sformatf("data%0d", i), dmi_addr_t'(AddrData0 + i), data_exp[i]);
      check_value($sformatf("data_o[%0d]", i), data_exp[i], data_o[i]);
    end
    for (int i = 0; i < ProgBufSize; i++) begin
      read_check($sformatf("progbuf%0d", i), dmi_addr_t'(AddrProgBuf0 + i), progbuf_exp[i]);
      check_value($sformatf("progbuf_o[%0d]", i), progbuf_exp[i], progbuf_o[i]);
    end
    // load from the hart side
    for (int i = 0; i < DataCount; i++) begin
      data_exp[i] = rand_word();
      data_i[i]  <= data_exp[i];
    end
    data_valid_i <= 1'b1;
    @(posedge clk_i);
    data_valid_i <= 1'b0;
    for (int i = 0; i < DataCount; i++) begin
      read_check($sformatf("data%0d", i), dmi_addr_t'(AddrData0 + i), data_exp[i]);
    end
  endtask

  task automatic test_command_errors();
    int        pulses;
    dmi_data_t word;
    dmi_data_t resp;
    pulses = cmd_pulses;
    word   = rand_word();
    dmi_write(AddrCommand, word);
    check_value("cmd_valid_o pulses", pulses + 1, cmd_pulses);
    check_value("cmd_o", word, cmd_o);
    read_check("command", AddrCommand, '0);
    read_check("abstractcs", AddrAbstractCs, acs_word(0, CmdErrNone));
    // writes while busy are dropped
    cmdbusy_i <= 1'b1;
    dmi_write(AddrData0, rand_word());
    dmi_write(AddrCommand, rand_word());
    check_value("cmd_valid_o pulses", pulses + 1, cmd_pulses);
    check_value("cmd_o", word, cmd_o);
    read_check("abstractcs", AddrAbstractCs, acs_word(1, CmdErrBusy));
    read_check("data0", AddrData0, data_exp[0]);
    cmdbusy_i <= 1'b0;
    dmi_write(AddrAbstractCs, 32'h0000_0700);
    read_check("abstractcs", AddrAbstractCs, acs_word(0, CmdErrNone));
    cmderror_valid_i <= 1'b1;
    cmderror_i       <= CmdErrException;
    @(posedge clk_i);
    cmderror_valid_i <= 1'b0;
    read_check("abstractcs", AddrAbstractCs, acs_word(0, CmdErrException));
    // hart error wins over the clearing write in the same cycle
    cmderror_valid_i <= 1'b1;
    cmderror_i       <= CmdErrBus;
    dmi_issue(DtmWrite, AddrAbstractCs, 32'h0000_0700);
    cmderror_valid_i <= 1'b0;
    dmi_collect(resp);
    check_value("write response", '0, resp);
    read_check("abstractcs", AddrAbstractCs, acs_word(0, CmdErrBus));
    dmi_write(AddrAbstractCs, 32'h0000_0700);
    read_check("abstractcs", AddrAbstractCs, acs_word(0, CmdErrNone));
  endtask

  task automatic test_backpressure();
    dmi_data_t resp;
    dmi_resp_ready_i <= 1'b0;
    dmi_issue(DtmRead, AddrDmControl, '0);
    dmi_issue(DtmRead, dmi_addr_t'(AddrData0 + 1), '0);
    // third request must wait on a full queue
    dmi_req_valid_i <= 1'b1;
    dmi_req_op_i    <= DtmRead;
    dmi_req_addr_i  <= AddrProgBuf0;
    for (int c = 0; c < 4; c++) begin
      @(negedge clk_i);
      check_value("dmi_req_ready_o", 0, dmi_req_ready_o);
      @(posedge clk_i);
    end
    dmi_req_valid_i  <= 1'b0;
    dmi_resp_ready_i <= 1'b1;
    dmi_collect(resp);
    check_value("first response", 32'h0000_0001, resp);
    dmi_collect(resp);
    check_value("second response", data_exp[1], resp);
    @(negedge clk_i);
    check_value("dmi_req_ready_o", 1, dmi_req_ready_o);
    @(posedge clk_i);
  endtask

  task automatic test_deactivation();
    dmi_write(AddrDmControl, 32'h8000_0003);
    check_value("haltreq_o", 2'b01, haltreq_o);
    check_value("ndmreset_o", 1, ndmreset_o);
    dmi_write(AddrDmControl, 32'h0000_0000);
    check_value("haltreq_o", 0, haltreq_o);
    check_value("ndmreset_o", 0, ndmreset_o);
    check_value("dmactive_o", 0, dmactive_o);
    // control bits stay cleared while inactive
    dmi_write(AddrDmControl, 32'h8000_0002);
    check_value("haltreq_o", 0, haltreq_o);
    check_value("ndmreset_o", 0, ndmreset_o);
    read_check("dmcontrol", AddrDmControl, '0);
    for (int i = 0; i < DataCount; i++) begin
      read_check($sformatf("data%0d", i), dmi_addr_t'(AddrData0 + i), '0);
      check_value($sformatf("data_o[%0d]", i), '0, data_o[i]);
    end
    for (int i = 0; i < ProgBufSize; i++) begin
      read_check($sformatf("progbuf%0d", i), dmi_addr_t'(AddrProgBuf0 + i), '0);
      check_value($sformatf("progbuf_o[%0d]", i), '0, progbuf_o[i]);
    end
  endtask

  initial begin
    rst_ni            = 1'b0;
    dmi_req_valid_i   = 1'b0;
    dmi_req_addr_i    = '0;
    dmi_req_op_i      = DtmNop;
    dmi_req_data_i    = '0;
    dmi_resp_ready_i  = 1'b1;
    halted_i          = '0;
    unavailable_i     = '0;
    resumeack_i       = '0;
    cmderror_valid_i  = 1'b0;
    cmderror_i        = CmdErrNone;
    cmdbusy_i         = 1'b0;
    data_i            = '0;
    data_valid_i      = 1'b0;
    errors            = 0;
    checks            = 0;
    tests             = 0;
    test_start_errors = 0;
    resumeack_clears  = 0;
    cmd_pulses        = 0;
    lcg_state         = 32'h0e0abf1b;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);

    test_reset_activation();
    finish_test("reset and activation");
    test_halt_resume();
    finish_test("halt and resume");
    test_data_progbuf();
    finish_test("data and program buffer");
    test_command_errors();
    finish_test("command and errors");
    test_backpressure();
    finish_test("back-pressure");
    test_deactivation();
    finish_test("deactivation");

    errors = errors + int'(dut.checker_i.assert_fails);
    $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- files.f
dm_pkg.sv
dm_reg_if.sv
dm_resp_fifo.sv
dm_hart_ctrl.sv
dm_abstract_cmd.sv
dm_csrs.sv
dm_csrs_checker.sv
tb_dm_csrs.sv

//--- Bender.yml
package:
  name: dm_csrs

sources:
  - dm_pkg.sv
  - dm_reg_if.sv
  - dm_resp_fifo.sv
  - dm_hart_ctrl.sv
  - dm_abstract_cmd.sv
  - dm_csrs.sv
  - target: test
    files:
      - dm_csrs_checker.sv
      - tb_dm_csrs.sv
